// ==== include/load_unit_macros.svh ====
// Width and depth constants for the data-cache load unit.
// Include this in any file that sizes a port or a register by these values;
// the guard makes repeated includes harmless.

`ifndef LOAD_UNIT_MACROS_SVH
`define LOAD_UNIT_MACROS_SVH

// ----------------------------------------
// datapath
// ----------------------------------------

// width of a data word and of a load result
`define LU_XLEN 64
// physical address width seen by the cache
`define LU_ADDR_W 32
// byte offset inside one data word, log2(LU_XLEN/8)
`define LU_ALIGN_BITS 3

// ----------------------------------------
// tracking
// ----------------------------------------

// scoreboard transaction id width
`define LU_TRANS_ID_BITS 3
// outstanding loads at the cache, at least 2
`define LU_NR_LDBUF 4
// slot id width, log2(LU_NR_LDBUF), doubles as cache request id
`define LU_LDBUF_ID_W 2

`endif

// ==== rtl/load_unit_pkg.sv ====
// Types shared by the load unit modules.
// Modules pull these in with a wildcard import in their header.

`default_nettype none

`include "load_unit_macros.svh"

package load_unit_pkg;

  // ----------------------------------------
  // load operations
  // ----------------------------------------
  // U suffix means zero extension, the rest sign extend
  typedef enum logic [2:0] {
    LD,
    LW,
    LWU,
    LH,
    LHU,
    LB,
    LBU
  } load_op_e;

  // ----------------------------------------
  // request side state machine
  // ----------------------------------------
  typedef enum logic [1:0] {
    IDLE,
    WAIT_GNT,
    SEND_TAG,
    WAIT_FLUSH
  } issue_state_e;

  // one outstanding load, what the response needs to be retired
  typedef struct packed {
    // scoreboard id to hand back with the result
    logic [`LU_TRANS_ID_BITS-1:0] trans_id;
    // low address bits, byte lane of the loaded value
    logic [`LU_ALIGN_BITS-1:0]    addr_offset;
    load_op_e                     op;
  } ldbuf_entry_t;

endpackage

`default_nettype wire

// ==== rtl/load_issue_ctrl.sv ====
// Request side of the load unit.
// Accepts a load from upstream, drives the cache index request until the grant,
// then strobes tag_valid one cycle later. A flush costs one kill cycle.
// All outputs are combinational from the state and the inputs.

`timescale 1ns/1ps
`default_nettype none

`include "load_unit_macros.svh"

module load_issue_ctrl
  import load_unit_pkg::*;
(
  input  wire logic                  clk_i,
  input  wire logic                  rst_ni,
  input  wire logic                  flush_i,
  // upstream request
  input  wire logic                  valid_i,
  input  wire logic [`LU_ADDR_W-1:0] vaddr_i,
  input  wire load_op_e              op_i,
  output logic                       pop_o,
  // cache request
  output logic                       data_req_o,
  output logic [`LU_ADDR_W-1:0]      address_o,
  output logic [1:0]                 data_size_o,
  input  wire logic                  data_gnt_i,
  output logic                       tag_valid_o,
  output logic                       kill_req_o,
  // load buffer
  input  wire logic                  ldbuf_full_i,
  output logic                       ldbuf_w_o
);

  issue_state_e state_q, state_d;
  logic         accept;

  // address is physical, goes to the cache as is
  assign address_o = vaddr_i;

  // transfer size as log2 of the byte count
  always_comb begin
    case (op_i)
      LD:       data_size_o = 2'd3;
      LW, LWU:  data_size_o = 2'd2;
      LH, LHU:  data_size_o = 2'd1;
      default:  data_size_o = 2'd0;
    endcase
  end

  // new load needs a free slot, and never starts in a flush cycle
  assign accept = valid_i && !ldbuf_full_i && !flush_i;

  // ----------------------------------------
  // issue state machine
  // ----------------------------------------
  always_comb begin
    state_d     = state_q;
    data_req_o  = 1'b0;
    pop_o       = 1'b0;
    tag_valid_o = 1'b0;
    kill_req_o  = 1'b0;

    case (state_q)
      IDLE, SEND_TAG: begin
        // tag of the previous grant goes out here
        if (state_q == SEND_TAG) begin
          tag_valid_o = 1'b1;
          state_d     = IDLE;
        end
        // back to back issue is allowed from both states
        if (accept) begin
          data_req_o = 1'b1;
          if (data_gnt_i) begin
            pop_o   = 1'b1;
            state_d = SEND_TAG;
          end else begin
            state_d = WAIT_GNT;
          end
        end
      end

      WAIT_GNT: begin
        // hold the request, upstream holds address and op stable
        data_req_o = 1'b1;
        if (data_gnt_i) begin
          pop_o   = 1'b1;
          state_d = SEND_TAG;
        end
      end

      WAIT_FLUSH: begin
        // kill whatever the cache has in its tag stage
        kill_req_o  = 1'b1;
        tag_valid_o = 1'b1;
        state_d     = IDLE;
      end

      default: state_d = IDLE;
    endcase

    // flush wins over every transition
    if (flush_i) begin
      state_d = WAIT_FLUSH;
    end
  end

  // every granted request gets a buffer slot
  assign ldbuf_w_o = data_req_o && data_gnt_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/load_buffer.sv ====
// Table of loads outstanding at the data cache.
// A slot is written at the grant and freed by the response carrying its id,
// so responses may return in any order. Flushed slots are retired silently.

`timescale 1ns/1ps
`default_nettype none

`include "load_unit_macros.svh"

module load_buffer
  import load_unit_pkg::*;
(
  input  wire logic                         clk_i,
  input  wire logic                         rst_ni,
  input  wire logic                         flush_i,
  // write side, from issue control
  input  wire logic                         ldbuf_w_i,
  input  wire logic [`LU_TRANS_ID_BITS-1:0] trans_id_i,
  input  wire logic [`LU_ADDR_W-1:0]        vaddr_i,
  input  wire load_op_e                     op_i,
  output logic                              full_o,
  output logic [`LU_LDBUF_ID_W-1:0]         free_id_o,
  // read side, cache response
  input  wire logic                         data_rvalid_i,
  input  wire logic [`LU_LDBUF_ID_W-1:0]    data_rid_i,
  output logic                              valid_o,
  output logic [`LU_TRANS_ID_BITS-1:0]      trans_id_o,
  output logic [`LU_ALIGN_BITS-1:0]         rd_offset_o,
  output load_op_e                          rd_op_o
);

  ldbuf_entry_t                      entries_q [`LU_NR_LDBUF];
  ldbuf_entry_t                      rd_entry;
  logic [`LU_NR_LDBUF-1:0]           valid_q, valid_d;
  logic [`LU_NR_LDBUF-1:0]           flushed_q, flushed_d;
  logic [`LU_LDBUF_ID_W-1:0]         free_id_q, free_id_d;
  logic [`LU_LDBUF_ID_W-1:0]         lowest_free;

  assign full_o    = &valid_q;
  assign free_id_o = free_id_q;

  // ----------------------------------------
  // slot bookkeeping
  // ----------------------------------------
  always_comb begin
    valid_d   = valid_q;
    flushed_d = flushed_q;
    // everything in flight now belongs to squashed instructions
    if (flush_i) begin
      flushed_d = flushed_q | valid_q;
    end
    // response frees its slot, flushed or not
    if (data_rvalid_i) begin
      valid_d[data_rid_i] = 1'b0;
    end
    // granted in a flush cycle counts as flushed too
    if (ldbuf_w_i) begin
      valid_d[free_id_q]   = 1'b1;
      flushed_d[free_id_q] = flush_i;
    end
  end

  // lowest free slot of the next cycle, scanned downwards so slot 0 wins
  always_comb begin
    lowest_free = '0;
    for (int i = `LU_NR_LDBUF - 1; i >= 0; i--) begin
      if (!valid_d[i]) begin
        lowest_free = i[`LU_LDBUF_ID_W-1:0];
      end
    end
  end

  // the slot id is the cache request id, it must not move while
  // a request waits for its grant, so only re-pick once it is taken
  assign free_id_d = valid_d[free_id_q] ? lowest_free : free_id_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q   <= '0;
      flushed_q <= '0;
      free_id_q <= '0;
    end else begin
      valid_q   <= valid_d;
      flushed_q <= flushed_d;
      free_id_q <= free_id_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (ldbuf_w_i) begin
      entries_q[free_id_q] <= '{trans_id:    trans_id_i,
                                addr_offset: vaddr_i[`LU_ALIGN_BITS-1:0],
                                op:          op_i};
    end
  end

  // ----------------------------------------
  // response lookup
  // ----------------------------------------
  assign rd_entry    = entries_q[data_rid_i];
  assign trans_id_o  = rd_entry.trans_id;
  assign rd_offset_o = rd_entry.addr_offset;
  assign rd_op_o     = rd_entry.op;

  // a flush in this very cycle already squashes the response
  assign valid_o = data_rvalid_i && valid_q[data_rid_i] && !flushed_q[data_rid_i] &&
                   !flush_i;

endmodule

`default_nettype wire

// ==== rtl/load_result_align.sv ====
// Load result formatting, purely combinational.
// Shifts the cache word down to the addressed byte and sign or zero extends
// it for the load width. The sign bit is picked straight from the raw word
// so it does not wait on the shifter.

`timescale 1ns/1ps
`default_nettype none

`include "load_unit_macros.svh"

module load_result_align
  import load_unit_pkg::*;
(
  input  wire logic [`LU_XLEN-1:0]       data_rdata_i,
  input  wire logic [`LU_ALIGN_BITS-1:0] offset_i,
  input  wire load_op_e                  op_i,
  output logic [`LU_XLEN-1:0]            result_o
);

  logic [`LU_XLEN-1:0]       shifted;
  logic [`LU_XLEN/8-1:0]     sign_bits;
  logic [`LU_ALIGN_BITS-1:0] msb_byte;
  logic                      is_signed;
  logic                      sign_bit;

  // byte offset times eight
  assign shifted = data_rdata_i >> {offset_i, 3'b000};

  // ----------------------------------------
  // sign selection
  // ----------------------------------------

  // top bit of every byte lane
  for (genvar i = 0; i < `LU_XLEN / 8; i++) begin : gen_sign_bits
    assign sign_bits[i] = data_rdata_i[8*i+7];
  end

  // lane holding the most significant loaded byte
  always_comb begin
    case (op_i)
      LW, LWU:  msb_byte = offset_i + 3'd3;
      LH, LHU:  msb_byte = offset_i + 3'd1;
      default:  msb_byte = offset_i;
    endcase
  end

  assign is_signed = op_i inside {LW, LH, LB};
  // unsigned loads pull the fill to zero
  assign sign_bit  = is_signed && sign_bits[msb_byte];

  // ----------------------------------------
  // result mux
  // ----------------------------------------
  always_comb begin
    case (op_i)
      LW, LWU:  result_o = {{(`LU_XLEN - 32){sign_bit}}, shifted[31:0]};
      LH, LHU:  result_o = {{(`LU_XLEN - 16){sign_bit}}, shifted[15:0]};
      LB, LBU:  result_o = {{(`LU_XLEN - 8){sign_bit}}, shifted[7:0]};
      // full double word, offset is zero for legal LD
      default:  result_o = shifted;
    endcase
  end

endmodule

`default_nettype wire

// ==== rtl/load_unit_top.sv ====
// Data-cache load unit for a 64-bit core.
// Issue control talks to the cache, the load buffer tracks outstanding loads
// by slot id, and the aligner formats each response. Results come out in
// cache response order with no back-pressure.

`timescale 1ns/1ps
`default_nettype none

`include "load_unit_macros.svh"

module load_unit_top
  import load_unit_pkg::*;
(
  input  wire logic                         clk_i,
  input  wire logic                         rst_ni,
  input  wire logic                         flush_i,
  // upstream request
  input  wire logic                         valid_i,
  input  wire logic [`LU_TRANS_ID_BITS-1:0] trans_id_i,
  input  wire logic [`LU_ADDR_W-1:0]        vaddr_i,
  input  wire load_op_e                     op_i,
  output logic                              pop_o,
  // cache request and strobes
  output logic                              data_req_o,
  output logic [`LU_ADDR_W-1:0]             address_o,
  output logic [1:0]                        data_size_o,
  output logic [`LU_LDBUF_ID_W-1:0]         data_id_o,
  input  wire logic                         data_gnt_i,
  output logic                              tag_valid_o,
  output logic                              kill_req_o,
  // cache response
  input  wire logic                         data_rvalid_i,
  input  wire logic [`LU_LDBUF_ID_W-1:0]    data_rid_i,
  input  wire logic [`LU_XLEN-1:0]          data_rdata_i,
  // result
  output logic                              valid_o,
  output logic [`LU_TRANS_ID_BITS-1:0]      trans_id_o,
  output logic [`LU_XLEN-1:0]               result_o
);

  logic                      ldbuf_w;
  logic                      ldbuf_full;
  logic [`LU_ALIGN_BITS-1:0] rd_offset;
  load_op_e                  rd_op;

  // request side
  load_issue_ctrl u_issue (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .flush_i      (flush_i),
    .valid_i      (valid_i),
    .vaddr_i      (vaddr_i),
    .op_i         (op_i),
    .pop_o        (pop_o),
    .data_req_o   (data_req_o),
    .address_o    (address_o),
    .data_size_o  (data_size_o),
    .data_gnt_i   (data_gnt_i),
    .tag_valid_o  (tag_valid_o),
    .kill_req_o   (kill_req_o),
    .ldbuf_full_i (ldbuf_full),
    .ldbuf_w_o    (ldbuf_w)
  );

  // free slot id is the cache request id
  load_buffer u_buffer (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .flush_i       (flush_i),
    .ldbuf_w_i     (ldbuf_w),
    .trans_id_i    (trans_id_i),
    .vaddr_i       (vaddr_i),
    .op_i          (op_i),
    .full_o        (ldbuf_full),
    .free_id_o     (data_id_o),
    .data_rvalid_i (data_rvalid_i),
    .data_rid_i    (data_rid_i),
    .valid_o       (valid_o),
    .trans_id_o    (trans_id_o),
    .rd_offset_o   (rd_offset),
    .rd_op_o       (rd_op)
  );

  // response formatting
  load_result_align u_align (
    .data_rdata_i (data_rdata_i),
    .offset_i     (rd_offset),
    .op_i         (rd_op),
    .result_o     (result_o)
  );

endmodule

`default_nettype wire

// ==== tests/load_unit_properties.sv ====
// Protocol checks for the load unit, bound to the top level by the testbench.
// Sampled on the falling clock edge, where every output has settled.

`timescale 1ns/1ps
`default_nettype none

`include "load_unit_macros.svh"

module load_unit_properties (
  input wire logic                      clk_i,
  input wire logic                      rst_ni,
  input wire logic                      flush_i,
  input wire logic                      pop_o,
  input wire logic                      data_req_o,
  input wire logic [`LU_ADDR_W-1:0]     address_o,
  input wire logic [`LU_LDBUF_ID_W-1:0] data_id_o,
  input wire logic                      data_gnt_i,
  input wire logic                      tag_valid_o,
  input wire logic                      kill_req_o,
  input wire logic                      valid_o
);

  // ----------------------------------------
  // reset
  // ----------------------------------------
  // first cycle out of reset, nothing active
  assert property (@(negedge clk_i) $rose(rst_ni) |->
                   !(data_req_o || pop_o || tag_valid_o || kill_req_o || valid_o))
    else $error("control output high right after reset");

  // ----------------------------------------
  // cache request handshake
  // ----------------------------------------
  // request, address and id frozen until the grant
  assert property (@(negedge clk_i) disable iff (!rst_ni)
                   data_req_o && !data_gnt_i && !flush_i |=>
                   data_req_o && $stable(address_o) && $stable(data_id_o))
    else $error("cache request changed before its grant");

  // tag strobe one cycle behind every grant
  assert property (@(negedge clk_i) disable iff (!rst_ni)
                   data_req_o && data_gnt_i |=> tag_valid_o)
    else $error("tag_valid_o missing after a grant");

  // kill cycle right after a flush
  assert property (@(negedge clk_i) disable iff (!rst_ni)
                   flush_i |=> kill_req_o && tag_valid_o)
    else $error("kill_req_o missing after a flush");

endmodule

`default_nettype wire

// ==== tests/load_unit_tb.sv ====
// Testbench for the load unit: upstream driver, a cache model with random
// grant delay and out-of-order responses, and a scoreboard of load results.
// Build with the file list and run load_unit_tb as the top module.

`timescale 1ns/1ps
`default_nettype none

`include "load_unit_macros.svh"

module load_unit_tb
  import load_unit_pkg::*;
();

  localparam int TIMEOUT = 200;
  localparam int NR_IDS  = 2 ** `LU_TRANS_ID_BITS;

  logic                         clk_i = 1'b0;
  logic                         rst_ni;
  logic                         flush_i;
  logic                         valid_i;
  logic [`LU_TRANS_ID_BITS-1:0] trans_id_i;
  logic [`LU_ADDR_W-1:0]        vaddr_i;
  load_op_e                     op_i;
  logic                         pop_o;
  logic                         data_req_o;
  logic [`LU_ADDR_W-1:0]        address_o;
  logic [1:0]                   data_size_o;
  logic [`LU_LDBUF_ID_W-1:0]    data_id_o;
  logic                         data_gnt_i;
  logic                         tag_valid_o;
  logic                         kill_req_o;
  logic                         data_rvalid_i;
  logic [`LU_LDBUF_ID_W-1:0]    data_rid_i;
  logic [`LU_XLEN-1:0]          data_rdata_i;
  logic                         valid_o;
  logic [`LU_TRANS_ID_BITS-1:0] trans_id_o;
  logic [`LU_XLEN-1:0]          result_o;

  // scoreboard, indexed by trans_id
  integer                       seed = 77;
  logic [`LU_XLEN-1:0]          exp_result [NR_IDS];
  logic                         exp_live [NR_IDS];
  logic                         id_busy [NR_IDS];
  // cache model, indexed by slot id
  logic [`LU_TRANS_ID_BITS-1:0] slot_tid [`LU_NR_LDBUF];
  logic [`LU_ADDR_W-1:0]        slot_addr [`LU_NR_LDBUF];
  logic [`LU_LDBUF_ID_W-1:0]    resp_q [$];
  int                           outstanding;
  int                           gnt_delay;
  logic                         resp_enable;
  logic                         prev_pop;
  logic                         prev_flush;
  logic                         prev_wait;
  logic [`LU_ADDR_W-1:0]        prev_addr;

  always #5 clk_i = ~clk_i;

  load_unit_top uut (.*);

  bind load_unit_top load_unit_properties u_props (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .flush_i     (flush_i),
    .pop_o       (pop_o),
    .data_req_o  (data_req_o),
    .address_o   (address_o),
    .data_id_o   (data_id_o),
    .data_gnt_i  (data_gnt_i),
    .tag_valid_o (tag_valid_o),
    .kill_req_o  (kill_req_o),
    .valid_o     (valid_o)
  );

  // ----------------------------------------
  // reference models
  // ----------------------------------------
  function automatic int rand_below(int n);
    return ($random(seed) & 32'h7fff_ffff) % n;
  endfunction

  // memory word, a mix of every word address bit
  function automatic logic [`LU_XLEN-1:0] mem_word(logic [`LU_ADDR_W-1:0] addr);
    logic [`LU_ADDR_W-1:0] w;
    w = {addr[`LU_ADDR_W-1:`LU_ALIGN_BITS], {`LU_ALIGN_BITS{1'b0}}};
    return {w * 32'h9e37_79b1, w ^ 32'hc3a5_5a3c};
  endfunction

  // shift down to the byte, then extend for the width
  function automatic logic [`LU_XLEN-1:0] expected_load(logic [`LU_XLEN-1:0] word,
                                                       logic [`LU_ALIGN_BITS-1:0] offset,
                                                       load_op_e op);
    logic [`LU_XLEN-1:0] v;
    v = word >> (8 * offset);
    case (op)
      LW:      return {{32{v[31]}}, v[31:0]};
      LWU:     return {32'b0, v[31:0]};
      LH:      return {{48{v[15]}}, v[15:0]};
      LHU:     return {48'b0, v[15:0]};
      LB:      return {{56{v[7]}}, v[7:0]};
      LBU:     return {56'b0, v[7:0]};
      default: return v;
    endcase
  endfunction

  function automatic int op_bytes(load_op_e op);
    case (op)
      LD:      return 8;
      LW, LWU: return 4;
      LH, LHU: return 2;
      default: return 1;
    endcase
  endfunction

  task automatic fail_now(string msg);
    $display("FAIL %0t: %s", $time, msg);
    $display("sim failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic abort_timeout(string what);
    $display("timeout while waiting for %s at %0t", what, $time);
    $display("sim failed");
    $fatal(1, "wait loop timed out");
  endtask

  // ----------------------------------------
  // cache model, grant and responses
  // ----------------------------------------
  always @(posedge clk_i) begin
    int idx;
    data_gnt_i <= (gnt_delay == 0);
    // random pick from the granted list gives out-of-order returns
    if (resp_enable && resp_q.size() > 0 && rand_below(2) == 0) begin
      idx = rand_below(resp_q.size());
      data_rvalid_i <= 1'b1;
      data_rid_i    <= resp_q[idx];
      data_rdata_i  <= mem_word(slot_addr[resp_q[idx]]);
      resp_q.delete(idx);
    end else begin
      data_rvalid_i <= 1'b0;
    end
  end

  // mid-cycle monitor, all outputs settled here
  always @(negedge clk_i) begin
    logic [`LU_TRANS_ID_BITS-1:0] tid;
    logic                         live;
    if (rst_ni) begin
      assert (pop_o == (data_req_o && data_gnt_i))
        else fail_now("pop_o does not follow the grant");
      assert (tag_valid_o == (prev_pop || prev_flush))
        else fail_now("tag_valid_o not one cycle after a grant or flush");
      assert (kill_req_o == prev_flush)
        else fail_now("kill_req_o not one cycle after flush");
      if (prev_wait) begin
        assert (data_req_o && address_o == prev_addr)
          else fail_now("cache request dropped or moved before its grant");
      end
      if (prev_flush) begin
        assert (!data_req_o) else fail_now("request accepted in the kill cycle");
      end
      if (outstanding == `LU_NR_LDBUF) begin
        assert (!data_req_o) else fail_now("request issued with the buffer full");
      end
      // physical address straight through, size is log2 of the byte count
      if (data_req_o) begin
        assert (address_o == vaddr_i)
          else fail_now($sformatf("address_o %h, expected %h", address_o, vaddr_i));
        assert ((1 << data_size_o) == op_bytes(op_i))
          else fail_now($sformatf("data_size_o %0d for a %0d byte load",
                                  data_size_o, op_bytes(op_i)));
      end
      // response side, flushed slots retire silently
      if (data_rvalid_i) begin
        tid  = slot_tid[data_rid_i];
        live = exp_live[tid] && !flush_i;
        assert (valid_o == live)
          else fail_now($sformatf("valid_o %b for slot %0d, expected %b",
                                  valid_o, data_rid_i, live));
        if (live) begin
          assert (trans_id_o == tid)
            else fail_now($sformatf("trans_id_o %0d, expected %0d", trans_id_o, tid));
          assert (result_o == exp_result[tid])
            else fail_now($sformatf("result_o %h for id %0d, expected %h",
                                    result_o, tid, exp_result[tid]));
        end
        exp_live[tid] = 1'b0;
        id_busy[tid]  = 1'b0;
        outstanding--;
      end else begin
        assert (!valid_o) else fail_now("valid_o without a cache response");
      end
      if (flush_i) begin
        for (int i = 0; i < NR_IDS; i++) begin
          exp_live[i] = 1'b0;
        end
      end
      // grant, slot now owned by this load
      if (pop_o) begin
        slot_tid[data_id_o]    = trans_id_i;
        slot_addr[data_id_o]   = address_o;
        exp_result[trans_id_i] = expected_load(mem_word(vaddr_i),
                                               vaddr_i[`LU_ALIGN_BITS-1:0], op_i);
        exp_live[trans_id_i]   = 1'b1;
        id_busy[trans_id_i]    = 1'b1;
        resp_q.push_back(data_id_o);
        outstanding++;
        gnt_delay = rand_below(4);
      end else if (data_req_o && gnt_delay > 0) begin
        gnt_delay--;
      end
      prev_pop   = pop_o;
      prev_flush = flush_i;
      prev_wait  = data_req_o && !data_gnt_i && !flush_i;
      prev_addr  = address_o;
    end
  end

  // ----------------------------------------
  // upstream driver
  // ----------------------------------------
  task automatic present_load(load_op_e op, logic [`LU_ALIGN_BITS-1:0] offset);
    int                    tid;
    logic [`LU_ADDR_W-1:0] rand_word;
    tid = 0;
    // lowest id with nothing at the cache
    while (id_busy[tid]) begin
      tid++;
    end
    rand_word = $random(seed);
    @(posedge clk_i);
    valid_i    <= 1'b1;
    trans_id_i <= tid[`LU_TRANS_ID_BITS-1:0];
    vaddr_i    <= {rand_word[`LU_ADDR_W-1:`LU_ALIGN_BITS], offset};
    op_i       <= op;
  endtask

  task automatic wait_pop();
    int n;
    n = 0;
    @(negedge clk_i);
    while (!pop_o) begin
      n++;
      if (n > TIMEOUT) begin
        abort_timeout("pop_o");
      end
      @(negedge clk_i);
    end
    @(posedge clk_i);
    valid_i <= 1'b0;
  endtask

  task automatic issue_load(load_op_e op, logic [`LU_ALIGN_BITS-1:0] offset);
    present_load(op, offset);
    wait_pop();
  endtask

  task automatic issue_random();
    load_op_e op;
    int       off;
    op  = load_op_e'(rand_below(7));
    off = rand_below(8) & ~(op_bytes(op) - 1);
    issue_load(op, off[`LU_ALIGN_BITS-1:0]);
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    resp_enable <= 1'b1;
    @(negedge clk_i);
    while (outstanding != 0) begin
      n++;
      if (n > TIMEOUT) begin
        abort_timeout("outstanding loads to return");
      end
      @(negedge clk_i);
    end
  endtask

  // flush in the cycle the caller has just started
  task automatic pulse_flush();
    flush_i <= 1'b1;
    @(posedge clk_i);
    flush_i <= 1'b0;
  endtask

  initial begin
    int leftover;
    rst_ni        = 1'b0;
    flush_i       = 1'b0;
    valid_i       = 1'b0;
    trans_id_i    = '0;
    vaddr_i       = '0;
    op_i          = LD;
    data_gnt_i    = 1'b0;
    data_rvalid_i = 1'b0;
    data_rid_i    = '0;
    data_rdata_i  = '0;
    resp_enable   = 1'b1;
    outstanding   = 0;
    gnt_delay     = 0;
    prev_pop      = 1'b0;
    prev_flush    = 1'b0;
    prev_wait     = 1'b0;
    prev_addr     = '0;
    for (int i = 0; i < NR_IDS; i++) begin
      exp_live[i] = 1'b0;
      id_busy[i]  = 1'b0;
    end
    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;

    // quiet period, no stimulus
    repeat (5) begin
      @(negedge clk_i);
      assert (!(data_req_o || pop_o || tag_valid_o || kill_req_o || valid_o))
        else fail_now("control output active with no stimulus");
    end

    // every op at every legal offset
    for (int k = 0; k < 7; k++) begin
      for (int off = 0; off < 8; off += op_bytes(load_op_e'(k))) begin
        issue_load(load_op_e'(k), off[`LU_ALIGN_BITS-1:0]);
      end
    end
    wait_drain();

    // buffer full, the next load must wait for a response
    resp_enable <= 1'b0;
    repeat (`LU_NR_LDBUF) begin
      issue_random();
    end
    present_load(LB, 3'd5);
    repeat (5) @(negedge clk_i);
    resp_enable <= 1'b1;
    wait_pop();
    wait_drain();

    // flush with loads at the cache while a new load waits upstream,
    // the waiting load goes out only after the kill cycle
    resp_enable <= 1'b0;
    repeat (3) begin
      issue_random();
    end
    present_load(LH, 3'd2);
    pulse_flush();
    wait_pop();
    wait_drain();
    repeat (40) begin
      issue_random();
    end
    wait_drain();

    // every accepted load got its one response
    leftover = 0;
    for (int i = 0; i < NR_IDS; i++) begin
      if (id_busy[i]) begin
        leftover++;
      end
    end
    if (leftover == 0) begin
      $display("sim passed");
      $finish;
    end else begin
      $display("%0d accepted loads never got a response", leftover);
      $display("sim failed");
      $fatal(1, "loads left at the cache at the end of the run");
    end
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+include
rtl/load_unit_pkg.sv
rtl/load_issue_ctrl.sv
rtl/load_buffer.sv
rtl/load_result_align.sv
rtl/load_unit_top.sv
tests/load_unit_properties.sv
tests/load_unit_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the load unit testbench with Verilator and run it.
# Exits non-zero when the run aborts or the log holds the fail message.
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f vlog.f --top-module load_unit_tb -Mdir obj_dir -o load_unit_sim

./obj_dir/load_unit_sim 2>&1 | tee sim.log

if grep -q "sim failed" sim.log; then
  echo "simulation reported a failure, see sim.log"
  exit 1
fi
echo "simulation finished, see sim.log"
